// File: vlog.f
+incdir+logic
logic/ahb_pkg.sv
logic/fabric_pkg.sv
logic/ahb_arb_regs.sv
logic/ahb_arbiter.sv
logic/ahb_decoder.sv
logic/ahb_bus_mux.sv
logic/ahb_fabric.sv
tb/tb_ahb_fabric.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_ahb_fabric -o sim_tb

# The simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	exit 1
fi

// File: tb/tb_ahb_fabric.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module tb_ahb_fabric
	import ahb_pkg::*;
	import fabric_pkg::*;
();

	// Fixed four-beat incrementing burst
	localparam hburst_t BURST_INCR4 = 3'b011;

	logic hclk;
	logic rst_n;
	ahb_req_t master_req [`FABRIC_NUM_MASTERS];
	master_vec_t hbusreq;
	master_vec_t hlock;
	ahb_rsp_t slave_rsp [1:`FABRIC_NUM_SLAVES-1];
	master_vec_t hgrant;
	logic hready;
	hresp_t hresp;
	hdata_t hrdata;
	ahb_req_t slave_bus;
	slave_vec_t hsel;
	master_idx_t hmaster;
	logic hmastlock;
	logic ahb_intr;

	logic [31:0] lfsr;
	hdata_t rdata;
	// Master 1 wins and master 2 is never granted
	int prio_set [`FABRIC_NUM_MASTERS] = '{2, 5, 0, 3};

	// Slave model state sampled mid-cycle
	logic snap_rst;
	logic snap_ready;
	slave_vec_t snap_sel;
	haddr_t snap_addr;
	logic busy [1:`FABRIC_NUM_SLAVES-1];
	haddr_t dp_addr [1:`FABRIC_NUM_SLAVES-1];
	int waits_left [1:`FABRIC_NUM_SLAVES-1];
	int drawn_waits [1:`FABRIC_NUM_SLAVES-1];

	ahb_fabric ahb_fabric_inst (
		.hclk       (hclk),
		.rst_n      (rst_n),
		.master_req (master_req),
		.hbusreq    (hbusreq),
		.hlock      (hlock),
		.slave_rsp  (slave_rsp),
		.hgrant     (hgrant),
		.hready     (hready),
		.hresp      (hresp),
		.hrdata     (hrdata),
		.slave_bus  (slave_bus),
		.hsel       (hsel),
		.hmaster    (hmaster),
		.hmastlock  (hmastlock),
		.ahb_intr   (ahb_intr)
	);

	initial begin
		hclk = 1'b0;
		forever begin
			#2 hclk = ~hclk;
		end
	end

	initial begin
		#100000;
		fail_stop("Simulation ran past its time limit");
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else fail_stop($sformatf("Error: %s got %h expected %h",
			name, got, exp));
	endtask

	// Fibonacci taps 32 22 2 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// Zero to three wait states
	function automatic int draw_waits();
		int w;
		w = 0;
		for (int i = 0; i < 2; i++) begin
			w = (w << 1) | int'(next_random_bit());
		end
		return w;
	endfunction

	// Registers never wait and unmapped takes one ERROR wait
	function automatic int expected_waits(input int region);
		if (region == 0) begin
			return 0;
		end
		if (region < `FABRIC_NUM_SLAVES) begin
			return drawn_waits[region];
		end
		return 1;
	endfunction

	always @(negedge hclk) begin
		snap_rst = rst_n;
		snap_ready = hready;
		snap_sel = hsel;
		snap_addr = slave_bus.haddr;
	end

	// Slaves 1 to 5 answer address XOR slave number after random waits
	initial begin
		for (int n = 1; n < `FABRIC_NUM_SLAVES; n++) begin
			busy[n] = 1'b0;
			dp_addr[n] = '0;
			waits_left[n] = 0;
			drawn_waits[n] = 0;
			slave_rsp[n] = '{hready_resp: 1'b1, hresp: `HRESP_OKAY, hrdata: '0};
		end
		forever begin
			@(posedge hclk);
			#0.5;
			for (int n = 1; n < `FABRIC_NUM_SLAVES; n++) begin
				if (!snap_rst) begin
					busy[n] = 1'b0;
				end else if (snap_ready) begin
					busy[n] = snap_sel[n];
					if (snap_sel[n]) begin
						dp_addr[n] = snap_addr;
						waits_left[n] = draw_waits();
						drawn_waits[n] = waits_left[n];
					end
				end else if (busy[n] && waits_left[n] != 0) begin
					waits_left[n] = waits_left[n] - 1;
				end
				slave_rsp[n].hready_resp = !busy[n] || waits_left[n] == 0;
				slave_rsp[n].hrdata = dp_addr[n] ^ hdata_t'(n);
			end
		end
	end

	task automatic next_drive();
		@(posedge hclk);
		#0.5;
	endtask

	task automatic wait_grant(input int m);
		int guard;
		guard = 0;
		@(negedge hclk);
		while (!(hgrant[m] && hready)) begin
			check_value("hgrant[2]", 32'(hgrant[2]), 32'h0);
			guard++;
			if (guard > 50) begin
				fail_stop($sformatf("Master %0d was never granted the bus", m));
			end
			@(negedge hclk);
		end
	endtask

	task automatic drive_beat(input int m, input haddr_t a, input logic wr,
			input hburst_t burst, input htrans_t trans);
		master_req[m].haddr = a;
		master_req[m].htrans = trans;
		master_req[m].hwrite = wr;
		master_req[m].hsize = 3'b010;
		master_req[m].hburst = burst;
		master_req[m].hprot = 4'b0011;
	endtask

	task automatic check_addr_phase(input int m, input haddr_t a, input int region,
			input logic wr, input htrans_t trans, input logic lock, input logic held);
		check_value("hmaster", 32'(hmaster), 32'(m));
		check_value("haddr", slave_bus.haddr, a);
		check_value("htrans", 32'(slave_bus.htrans), 32'(trans));
		check_value("hwrite", 32'(slave_bus.hwrite), 32'(wr));
		check_value("hsel", 32'(hsel),
			region < `FABRIC_NUM_SLAVES ? 32'(1) << region : 32'h0);
		check_value("hmastlock", 32'(hmastlock), 32'(lock));
		if (held) begin
			check_value("hgrant", 32'(hgrant), 32'(1) << m);
		end
	endtask

	// Full owned sequence of request, beats and release
	task automatic xfer(input int m, input haddr_t addr, input logic wr, input hdata_t wdata,
			input int nbeats, input hburst_t burst, input logic lock, input int rival,
			output hdata_t rd);
		int ab;
		int db;
		int waits;
		int guard;
		int region;
		logic rdy;
		logic held;
		region = int'(addr[31:28]);
		rd = '0;
		hbusreq[m] = 1'b1;
		hlock[m] = lock;
		wait_grant(m);
		next_drive();
		if (rival >= 0) begin
			hbusreq[rival] = 1'b1;
		end
		ab = 0;
		db = -1;
		waits = 0;
		guard = 0;
		drive_beat(m, addr, wr, burst, `HTRANS_NONSEQ);
		while (ab < nbeats || db >= 0) begin
			@(negedge hclk);
			guard++;
			if (guard > 100) begin
				fail_stop("A transfer never completed");
			end
			if (ab < nbeats) begin
				held = rival >= 0 && (lock || (burst == BURST_INCR4 && ab < 3));
				check_addr_phase(m, addr + 32'(4 * ab), region, wr,
					ab == 0 ? `HTRANS_NONSEQ : `HTRANS_SEQ, lock, held);
			end
			if (db >= 0) begin
				check_value("hresp", 32'(hresp), region < `FABRIC_NUM_SLAVES ?
					32'(`HRESP_OKAY) : 32'(`HRESP_ERROR));
				if (wr) begin
					check_value("hwdata", slave_bus.hwdata, wdata ^ 32'(db));
				end
				if (!hready) begin
					waits++;
				end else begin
					check_value("wait states", 32'(waits), 32'(expected_waits(region)));
					rd = hrdata;
					if (!wr && region >= 1 && region < `FABRIC_NUM_SLAVES) begin
						check_value("hrdata", hrdata, (addr + 32'(4 * db)) ^ 32'(region));
					end
				end
			end
			rdy = hready;
			next_drive();
			if (rdy) begin
				waits = 0;
				db = (ab < nbeats) ? ab : -1;
				if (ab < nbeats) begin
					ab++;
				end
				if (db >= 0) begin
					master_req[m].hwdata = wdata ^ 32'(db);
				end
				if (ab < nbeats) begin
					drive_beat(m, addr + 32'(4 * ab), wr, burst, `HTRANS_SEQ);
				end else begin
					master_req[m].htrans = `HTRANS_IDLE;
				end
			end
		end
		hbusreq[m] = 1'b0;
		hlock[m] = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] offset, input hdata_t value);
		hdata_t rd;
		xfer(0, 32'(offset), 1'b1, value, 1, `HBURST_SINGLE, 1'b0, -1, rd);
	endtask

	task automatic read_reg(input string name, input logic [7:0] offset, input hdata_t exp);
		hdata_t rd;
		xfer(0, 32'(offset), 1'b0, '0, 1, `HBURST_SINGLE, 1'b0, -1, rd);
		check_value(name, rd, exp);
	endtask

	task automatic wait_intr(input logic exp);
		int guard;
		guard = 0;
		@(negedge hclk);
		while (ahb_intr !== exp) begin
			guard++;
			if (guard > 20) begin
				fail_stop("Interrupt line never reached its expected level");
			end
			@(negedge hclk);
		end
		next_drive();
	endtask

	initial begin
		lfsr = 32'h9cb9669f;
		rst_n = 1'b0;
		hbusreq = '0;
		hlock = '0;
		for (int m = 0; m < `FABRIC_NUM_MASTERS; m++) begin
			master_req[m] = '0;
		end
		repeat (2) @(posedge hclk);
		#0.5;
		rst_n = 1'b1;

		// Reset state
		@(negedge hclk);
		check_value("hgrant", 32'(hgrant), 32'h1);
		check_value("hready", 32'(hready), 32'h1);
		check_value("hresp", 32'(hresp), 32'(`HRESP_OKAY));
		check_value("hsel", 32'(hsel), 32'h0);
		check_value("ahb_intr", 32'(ahb_intr), 32'h0);
		next_drive();

		// Priority registers round trip
		for (int m = 0; m < `FABRIC_NUM_MASTERS; m++) begin
			write_reg(8'(`ARB_REG_PRIO0 + 4 * m), 32'(prio_set[m]));
		end
		for (int m = 0; m < `FABRIC_NUM_MASTERS; m++) begin
			read_reg("prio", 8'(`ARB_REG_PRIO0 + 4 * m), 32'(prio_set[m]));
		end

		// Everybody requests and the highest nonzero priority wins
		hbusreq = '1;
		wait_grant(1);
		check_value("hgrant", 32'(hgrant), 32'h2);
		next_drive();
		@(negedge hclk);
		check_value("hmaster", 32'(hmaster), 32'h1);
		next_drive();
		hbusreq = '0;

		// Every region with a write and then a burst of reads
		for (int r = 1; r < `FABRIC_NUM_SLAVES; r++) begin
			xfer(0, (32'(r) << 28) | 32'h100, 1'b1, 32'ha500_0000 | 32'(r), 1,
				`HBURST_SINGLE, 1'b0, -1, rdata);
			xfer(3, (32'(r) << 28) | 32'h200, 1'b0, '0, 4, BURST_INCR4, 1'b0, -1, rdata);
		end

		// Unmapped read
		xfer(0, 32'h7000_0000, 1'b0, '0, 1, `HBURST_SINGLE, 1'b0, -1, rdata);

		// Burst cut after two beats
		write_reg(`ARB_REG_IRQ_EN, 32'h1);
		xfer(3, 32'h1000_0400, 1'b1, 32'h0000_0bad, 2, BURST_INCR4, 1'b0, -1, rdata);
		wait_intr(1'b1);
		read_reg("ebt_stat", `ARB_REG_EBT_STAT, 32'h1);
		write_reg(`ARB_REG_EBT_STAT, 32'h1);
		wait_intr(1'b0);
		read_reg("ebt_stat", `ARB_REG_EBT_STAT, 32'h0);

		// Complete burst raises nothing
		xfer(3, 32'h2000_0400, 1'b1, 32'h0000_0f00, 4, BURST_INCR4, 1'b0, -1, rdata);
		repeat (6) begin
			@(negedge hclk);
			check_value("ahb_intr", 32'(ahb_intr), 32'h0);
		end
		next_drive();
		read_reg("ebt_stat", `ARB_REG_EBT_STAT, 32'h0);

		// Locked master 3 keeps the bus against master 1
		xfer(3, 32'h4000_0000, 1'b1, 32'h1234_0000, 3, `HBURST_INCR, 1'b1, 1, rdata);
		hbusreq[1] = 1'b0;
		// Master 0 burst holds against master 1
		// Last write beat lands after master 1 owns the address bus
		xfer(0, 32'h5000_0000, 1'b1, 32'h5678_0000, 4, BURST_INCR4, 1'b0, 1, rdata);
		hbusreq[1] = 1'b0;

		next_drive();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/ahb_fabric.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module ahb_fabric
	import ahb_pkg::*;
	import fabric_pkg::*;
(
	input wire hclk,
	input wire rst_n,
	input wire ahb_req_t master_req [`FABRIC_NUM_MASTERS],
	input wire master_vec_t hbusreq,
	input wire master_vec_t hlock,
	input wire ahb_rsp_t slave_rsp [1:`FABRIC_NUM_SLAVES-1],
	output wire master_vec_t hgrant,
	output wire hready,
	output wire hresp_t hresp,
	output wire hdata_t hrdata,
	output wire ahb_req_t slave_bus,
	output wire slave_vec_t hsel,
	output wire master_idx_t hmaster,
	output wire hmastlock,
	output wire ahb_intr
);

	// Data-phase owner for write data routing
	master_idx_t hmaster_data;
	prio_t prio [`FABRIC_NUM_MASTERS];
	logic ebt_event;
	ahb_rsp_t reg_rsp;
	ahb_rsp_t default_rsp;
	ahb_rsp_t all_rsp [`FABRIC_NUM_SLAVES];

	// Register block takes slot 0
	always_comb begin
		all_rsp[0] = reg_rsp;
		for (int s = 1; s < `FABRIC_NUM_SLAVES; s++) begin
			all_rsp[s] = slave_rsp[s];
		end
	end

	ahb_arbiter ahb_arbiter_inst (
		.hclk         (hclk),
		.rst_n        (rst_n),
		.hbusreq      (hbusreq),
		.hlock        (hlock),
		.owner_trans  (slave_bus.htrans),
		.owner_burst  (slave_bus.hburst),
		.hready       (hready),
		.prio         (prio),
		.hgrant       (hgrant),
		.hmaster      (hmaster),
		.hmaster_data (hmaster_data),
		.hmastlock    (hmastlock),
		.ebt_event    (ebt_event)
	);

	// Slave 0 steering the arbiter
	ahb_arb_regs ahb_arb_regs_inst (
		.hclk      (hclk),
		.rst_n     (rst_n),
		.sel       (hsel[0]),
		.slave_bus (slave_bus),
		.hready    (hready),
		.ebt_event (ebt_event),
		.prio      (prio),
		.rsp       (reg_rsp),
		.ahb_intr  (ahb_intr)
	);

	ahb_decoder ahb_decoder_inst (
		.hclk        (hclk),
		.rst_n       (rst_n),
		.haddr       (slave_bus.haddr),
		.htrans      (slave_bus.htrans),
		.hready      (hready),
		.hsel        (hsel),
		.default_rsp (default_rsp)
	);

	ahb_bus_mux ahb_bus_mux_inst (
		.hclk         (hclk),
		.rst_n        (rst_n),
		.master_req   (master_req),
		.hmaster      (hmaster),
		.hmaster_data (hmaster_data),
		.hsel         (hsel),
		.slave_rsp    (all_rsp),
		.default_rsp  (default_rsp),
		.slave_bus    (slave_bus),
		.hready       (hready),
		.hresp        (hresp),
		.hrdata       (hrdata)
	);

endmodule

`default_nettype wire

// File: logic/ahb_bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module ahb_bus_mux
	import ahb_pkg::*;
	import fabric_pkg::*;
(
	input wire hclk,
	input wire rst_n,
	input wire ahb_req_t master_req [`FABRIC_NUM_MASTERS],
	input wire master_idx_t hmaster,
	input wire master_idx_t hmaster_data,
	input wire slave_vec_t hsel,
	input wire ahb_rsp_t slave_rsp [`FABRIC_NUM_SLAVES],
	input wire ahb_rsp_t default_rsp,
	output ahb_req_t slave_bus,
	output logic hready,
	output hresp_t hresp,
	output hdata_t hrdata
);

	// Slave owning the current data phase
	slave_vec_t data_sel;
	ahb_rsp_t sel_rsp;

	// Address and control from the address owner
	// Write data lags one phase behind
	always_comb begin
		slave_bus = master_req[hmaster];
		slave_bus.hwdata = master_req[hmaster_data].hwdata;
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			data_sel <= '0;
		end else if (hready) begin
			data_sel <= hsel;
		end
	end

	// Default slave answers when nothing was selected
	always_comb begin
		sel_rsp = default_rsp;
		for (int s = 0; s < `FABRIC_NUM_SLAVES; s++) begin
			if (data_sel[s]) begin
				sel_rsp = slave_rsp[s];
			end
		end
	end

	assign hready = sel_rsp.hready_resp;
	assign hresp = sel_rsp.hresp;
	assign hrdata = sel_rsp.hrdata;

endmodule

`default_nettype wire

// File: logic/ahb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module ahb_decoder
	import ahb_pkg::*;
	import fabric_pkg::*;
(
	input wire hclk,
	input wire rst_n,
	input wire haddr_t haddr,
	input wire htrans_t htrans,
	input wire hready,
	output slave_vec_t hsel,
	output ahb_rsp_t default_rsp
);

	// Region bases with slave 0 at address zero
	localparam haddr_t BASE [`FABRIC_NUM_SLAVES] = '{
		32'h0000_0000, `FABRIC_S1_BASE, `FABRIC_S2_BASE,
		`FABRIC_S3_BASE, `FABRIC_S4_BASE, `FABRIC_S5_BASE
	};

	logic active;
	logic unmapped;
	err_state_e err_state;

	// NONSEQ and SEQ only
	assign active = (htrans == `HTRANS_NONSEQ) || (htrans == `HTRANS_SEQ);

	always_comb begin
		hsel = '0;
		for (int s = 0; s < `FABRIC_NUM_SLAVES; s++) begin
			if (haddr[31:`FABRIC_REGION_BITS] == BASE[s][31:`FABRIC_REGION_BITS]) begin
				hsel[s] = active;
			end
		end
	end

	// Active transfer that hit no region
	assign unmapped = active && (hsel == '0);

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			err_state <= ERR_IDLE;
		end else begin
			case (err_state)
				ERR_FIRST: err_state <= ERR_SECOND;
				// Back-to-back unmapped accesses restart the sequence
				default: err_state <= (hready && unmapped) ? ERR_FIRST : ERR_IDLE;
			endcase
		end
	end

	// Wait with ERROR and then ready with ERROR
	always_comb begin
		default_rsp.hrdata = '0;
		case (err_state)
			ERR_FIRST: begin
				default_rsp.hready_resp = 1'b0;
				default_rsp.hresp = `HRESP_ERROR;
			end
			ERR_SECOND: begin
				default_rsp.hready_resp = 1'b1;
				default_rsp.hresp = `HRESP_ERROR;
			end
			default: begin
				default_rsp.hready_resp = 1'b1;
				default_rsp.hresp = `HRESP_OKAY;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/ahb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module ahb_arbiter
	import ahb_pkg::*;
	import fabric_pkg::*;
(
	input wire hclk,
	input wire rst_n,
	input wire master_vec_t hbusreq,
	input wire master_vec_t hlock,
	input wire htrans_t owner_trans,
	input wire hburst_t owner_burst,
	input wire hready,
	input wire prio_t prio [`FABRIC_NUM_MASTERS],
	output master_vec_t hgrant,
	output master_idx_t hmaster,
	output master_idx_t hmaster_data,
	output logic hmastlock,
	output logic ebt_event
);

	// Beats still owed by the owner's fixed-length burst
	logic [3:0] beats_left;
	logic [3:0] beats_nxt;
	master_idx_t grant_idx;
	master_idx_t winner;
	prio_t best_prio;
	logic hold;

	// Beat count after the transfer now on the address bus
	always_comb begin
		beats_nxt = beats_left;
		case (owner_trans)
			`HTRANS_NONSEQ: begin
				if (owner_burst == `HBURST_SINGLE || owner_burst == `HBURST_INCR) begin
					beats_nxt = 4'd0;
				end else begin
					// Burst length of 4 8 or 16 from hburst[2:1]
					case (owner_burst[2:1])
						2'b01: beats_nxt = 4'd3;
						2'b10: beats_nxt = 4'd7;
						default: beats_nxt = 4'd15;
					endcase
				end
			end
			`HTRANS_SEQ: begin
				if (beats_left != 4'd0) begin
					beats_nxt = beats_left - 4'd1;
				end
			end
			`HTRANS_BUSY: beats_nxt = beats_left;
			default: beats_nxt = 4'd0;
		endcase
	end

	// Held while locked or mid-burst or before the new owner reaches the address bus
	assign hold = hlock[grant_idx] || (beats_nxt > 4'd1) || (hmaster != grant_idx);

	// Highest nonzero priority with ties to the lowest index
	always_comb begin
		winner = '0;
		best_prio = '0;
		for (int m = 0; m < `FABRIC_NUM_MASTERS; m++) begin
			if (hbusreq[m] && prio[m] > best_prio) begin
				winner = master_idx_t'(m);
				best_prio = prio[m];
			end
		end
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			grant_idx <= '0;
			hgrant <= master_vec_t'(1);
			hmaster <= '0;
			hmaster_data <= '0;
			hmastlock <= 1'b0;
			beats_left <= '0;
			ebt_event <= 1'b0;
		end else begin
			ebt_event <= 1'b0;
			if (hready) begin
				// Parks on master 0 when nobody is eligible
				if (!hold) begin
					grant_idx <= winner;
					hgrant <= master_vec_t'(1) << winner;
				end
				hmaster <= grant_idx;
				hmaster_data <= hmaster;
				hmastlock <= hlock[grant_idx];
				beats_left <= beats_nxt;
				// Burst cut short by IDLE or a fresh NONSEQ
				ebt_event <= (beats_left != 4'd0) &&
					(owner_trans == `HTRANS_IDLE || owner_trans == `HTRANS_NONSEQ);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/ahb_arb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

module ahb_arb_regs
	import ahb_pkg::*;
	import fabric_pkg::*;
(
	input wire hclk,
	input wire rst_n,
	input wire sel,
	input wire ahb_req_t slave_bus,
	input wire hready,
	input wire ebt_event,
	output prio_t prio [`FABRIC_NUM_MASTERS],
	output ahb_rsp_t rsp,
	output logic ahb_intr
);

	// Data-phase copy of the address phase
	logic dp_write;
	logic [7:0] dp_addr;
	logic irq_en;
	logic ebt_stat;
	hdata_t rd_data;

	// Write pending for the data phase
	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			dp_write <= 1'b0;
		end else if (hready) begin
			dp_write <= sel && slave_bus.hwrite;
		end
	end

	// Register offset of the current access
	always_ff @(posedge hclk) begin
		if (hready && sel) begin
			dp_addr <= slave_bus.haddr[7:0];
		end
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int m = 0; m < `FABRIC_NUM_MASTERS; m++) begin
				prio[m] <= 4'd1;
			end
			irq_en <= 1'b0;
			ebt_stat <= 1'b0;
		end else begin
			if (dp_write && hready) begin
				case (dp_addr)
					`ARB_REG_PRIO0: prio[0] <= slave_bus.hwdata[3:0];
					`ARB_REG_PRIO1: prio[1] <= slave_bus.hwdata[3:0];
					`ARB_REG_PRIO2: prio[2] <= slave_bus.hwdata[3:0];
					`ARB_REG_PRIO3: prio[3] <= slave_bus.hwdata[3:0];
					`ARB_REG_IRQ_EN: irq_en <= slave_bus.hwdata[0];
					// Write one to clear
					`ARB_REG_EBT_STAT: if (slave_bus.hwdata[0]) ebt_stat <= 1'b0;
					default: ;
				endcase
			end
			// New event wins over a clear in the same cycle
			if (ebt_event) begin
				ebt_stat <= 1'b1;
			end
		end
	end

	// Readback with zero for unused offsets
	always_comb begin
		rd_data = '0;
		case (dp_addr)
			`ARB_REG_PRIO0: rd_data = hdata_t'(prio[0]);
			`ARB_REG_PRIO1: rd_data = hdata_t'(prio[1]);
			`ARB_REG_PRIO2: rd_data = hdata_t'(prio[2]);
			`ARB_REG_PRIO3: rd_data = hdata_t'(prio[3]);
			`ARB_REG_IRQ_EN: rd_data = hdata_t'(irq_en);
			`ARB_REG_EBT_STAT: rd_data = hdata_t'(ebt_stat);
			default: rd_data = '0;
		endcase
	end

	// Zero wait states and always OKAY
	assign rsp = '{hready_resp: 1'b1, hresp: `HRESP_OKAY, hrdata: rd_data};
	assign ahb_intr = ebt_stat && irq_en;

endmodule

`default_nettype wire

// File: logic/fabric_pkg.sv
`default_nettype none

`include "fabric_consts.svh"

package fabric_pkg;

	// Master numbering and request vectors
	typedef logic [$clog2(`FABRIC_NUM_MASTERS)-1:0] master_idx_t;
	typedef logic [`FABRIC_NUM_MASTERS-1:0] master_vec_t;

	// Zero keeps a master off the bus
	typedef logic [3:0] prio_t;

	// One select bit per slave with bit 0 internal
	typedef logic [`FABRIC_NUM_SLAVES-1:0] slave_vec_t;

	// Two-cycle ERROR sequence of the default slave
	typedef enum logic [1:0] {
		ERR_IDLE,
		ERR_FIRST,
		ERR_SECOND
	} err_state_e;

endpackage

`default_nettype wire

// File: logic/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

	// Plain AHB signal widths
	typedef logic [31:0] haddr_t;
	typedef logic [31:0] hdata_t;
	typedef logic [1:0] htrans_t;
	typedef logic [2:0] hsize_t;
	typedef logic [2:0] hburst_t;
	typedef logic [3:0] hprot_t;
	typedef logic [1:0] hresp_t;

	// Everything a master drives onto the bus
	typedef struct packed {
		haddr_t haddr;
		htrans_t htrans;
		logic hwrite;
		hsize_t hsize;
		hburst_t hburst;
		hprot_t hprot;
		hdata_t hwdata;
	} ahb_req_t;

	// Everything a slave drives back
	typedef struct packed {
		logic hready_resp;
		hresp_t hresp;
		hdata_t hrdata;
	} ahb_rsp_t;

endpackage

`default_nettype wire

// File: logic/fabric_consts.svh
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// Bus population with slave 0 as the arbiter register block
`define FABRIC_NUM_MASTERS 4
`define FABRIC_NUM_SLAVES 6

// Address map in 256 MB regions
`define FABRIC_REGION_BITS 28
`define FABRIC_S1_BASE 32'h1000_0000
`define FABRIC_S2_BASE 32'h2000_0000
`define FABRIC_S3_BASE 32'h3000_0000
`define FABRIC_S4_BASE 32'h4000_0000
`define FABRIC_S5_BASE 32'h5000_0000

// Arbiter register offsets
`define ARB_REG_PRIO0 8'h00
`define ARB_REG_PRIO1 8'h04
`define ARB_REG_PRIO2 8'h08
`define ARB_REG_PRIO3 8'h0C
`define ARB_REG_IRQ_EN 8'h10
`define ARB_REG_EBT_STAT 8'h14

// AHB transfer codes
`define HTRANS_IDLE 2'b00
`define HTRANS_BUSY 2'b01
`define HTRANS_NONSEQ 2'b10
`define HTRANS_SEQ 2'b11
`define HRESP_OKAY 2'b00
`define HRESP_ERROR 2'b01
`define HBURST_SINGLE 3'b000
`define HBURST_INCR 3'b001

`endif
